/* logic/ula_data_pkg.sv */
// Data word definitions shared by every ALU pipeline stage
// Import into a module body, or use scoped names in a port list

`default_nettype none

package ula_data_pkg;

	// ************************************************************************
	// Data word
	// ************************************************************************

	localparam int word_width = 32;                    // Memory word and accumulator width

	typedef logic signed [word_width-1:0] word_t;      // Operands and results, two's complement

	// Low operand bits used as shift amount
	// Anything above them set means a shift of 32 or more
	localparam int shamt_width = 5;

endpackage

`default_nettype wire

/* logic/ula_op_pkg.sv */
// Opcode numbers and internal operation classes of the accumulator ALU
// Decode maps an opcode to a unit and a sub-operation that execute switches on

`default_nettype none

package ula_op_pkg;

	typedef logic [5:0] op_t;                          // Opcode as seen on the ALU input

	// ************************************************************************
	// Opcode numbers of the accumulator machine
	// ************************************************************************

	localparam op_t op_nop   = 6'd0;                   // Result is accumulator
	localparam op_t op_lod   = 6'd1;                   // Result is memory word
	localparam op_t op_add   = 6'd2;
	localparam op_t op_mlt   = 6'd4;                   // Low half of product
	localparam op_t op_sgn   = 6'd9;
	localparam op_t op_neg   = 6'd11;
	localparam op_t op_neg_m = 6'd12;
	localparam op_t op_abs   = 6'd15;
	localparam op_t op_abs_m = 6'd16;
	localparam op_t op_pst   = 6'd19;
	localparam op_t op_pst_m = 6'd20;
	localparam op_t op_and   = 6'd29;
	localparam op_t op_orr   = 6'd30;
	localparam op_t op_xor   = 6'd31;
	localparam op_t op_inv   = 6'd32;
	localparam op_t op_inv_m = 6'd33;
	localparam op_t op_lan   = 6'd34;
	localparam op_t op_lor   = 6'd35;
	localparam op_t op_lin   = 6'd36;
	localparam op_t op_lin_m = 6'd37;
	localparam op_t op_les   = 6'd38;
	localparam op_t op_gre   = 6'd40;
	localparam op_t op_equ   = 6'd42;
	localparam op_t op_shl   = 6'd43;
	localparam op_t op_shr   = 6'd44;
	localparam op_t op_srs   = 6'd45;

	// ************************************************************************
	// Functional units and sub-operations
	// ************************************************************************

	typedef enum logic [2:0] {
		unit_move,                                     // NOP and LOD
		unit_arith,
		unit_unary,                                    // Both accumulator and _M forms
		unit_bitwise,
		unit_cond,
		unit_compare,
		unit_shift
	} unit_t;

	typedef logic [1:0] sub_t;                         // Only meaningful inside one unit

	// Arithmetic unit
	localparam sub_t sub_add = 2'd0;
	localparam sub_t sub_mlt = 2'd1;
	localparam sub_t sub_sgn = 2'd2;

	// One-operand unit
	localparam sub_t sub_neg = 2'd0;
	localparam sub_t sub_abs = 2'd1;
	localparam sub_t sub_pst = 2'd2;
	localparam sub_t sub_inv = 2'd3;

	localparam sub_t sub_and = 2'd0;
	localparam sub_t sub_orr = 2'd1;
	localparam sub_t sub_xor = 2'd2;

	localparam sub_t sub_lan = 2'd0;                   // Logical conditions
	localparam sub_t sub_lor = 2'd1;
	localparam sub_t sub_lin = 2'd2;

	localparam sub_t sub_les = 2'd0;
	localparam sub_t sub_gre = 2'd1;
	localparam sub_t sub_equ = 2'd2;

	localparam sub_t sub_shl = 2'd0;                   // Shifter
	localparam sub_t sub_shr = 2'd1;
	localparam sub_t sub_srs = 2'd2;

endpackage

`default_nettype wire

/* logic/ula_decode.sv */
// First ALU stage doing opcode decode and operand routing
// Registers unit, sub-operation and operands one cycle after the op_valid strobe

`default_nettype none

module ula_decode (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 op_valid,     // Single-cycle strobe
	input  ula_op_pkg::op_t      op,
	input  ula_data_pkg::word_t  in1,          // Memory word
	input  ula_data_pkg::word_t  in2,          // Accumulator
	output logic                 dec_valid,
	output ula_op_pkg::unit_t    dec_unit,
	output ula_op_pkg::sub_t     dec_sub,
	output ula_data_pkg::word_t  dec_a,        // in1, or source of a one-operand op
	output ula_data_pkg::word_t  dec_b,        // Always the accumulator
	output logic                 dec_error
);

	import ula_data_pkg::*;
	import ula_op_pkg::*;

	unit_t unit_next;
	sub_t  sub_next;
	word_t a_next;
	logic  error_next;

	// ************************************************************************
	// Opcode classification
	// ************************************************************************

	always_comb begin
		unit_next  = unit_move;
		error_next = 1'b0;
		case (op)
			op_nop, op_lod:                      unit_next = unit_move;
			op_add, op_mlt, op_sgn:              unit_next = unit_arith;
			op_neg, op_neg_m, op_abs, op_abs_m,
			op_pst, op_pst_m, op_inv, op_inv_m:  unit_next = unit_unary;
			op_and, op_orr, op_xor:              unit_next = unit_bitwise;
			op_lan, op_lor, op_lin, op_lin_m:    unit_next = unit_cond;
			op_les, op_gre, op_equ:              unit_next = unit_compare;
			op_shl, op_shr, op_srs:              unit_next = unit_shift;
			default:                             error_next = 1'b1;  // Float, div and gaps
		endcase
	end

	always_comb begin
		case (op)
			op_add:            sub_next = sub_add;
			op_mlt:            sub_next = sub_mlt;
			op_sgn:            sub_next = sub_sgn;
			op_neg, op_neg_m:  sub_next = sub_neg;
			op_abs, op_abs_m:  sub_next = sub_abs;
			op_pst, op_pst_m:  sub_next = sub_pst;
			op_inv, op_inv_m:  sub_next = sub_inv;
			op_and:            sub_next = sub_and;
			op_orr:            sub_next = sub_orr;
			op_xor:            sub_next = sub_xor;
			op_lan:            sub_next = sub_lan;
			op_lor:            sub_next = sub_lor;
			op_lin, op_lin_m:  sub_next = sub_lin;
			op_les:            sub_next = sub_les;
			op_gre:            sub_next = sub_gre;
			op_equ:            sub_next = sub_equ;
			op_shl:            sub_next = sub_shl;
			op_shr:            sub_next = sub_shr;
			op_srs:            sub_next = sub_srs;
			default:           sub_next = '0;          // Moves ignore it
		endcase
	end

	// Port a carries in2 for NOP and the accumulator forms, in1 otherwise
	always_comb begin
		case (op)
			op_nop, op_neg, op_abs, op_pst, op_inv, op_lin:  a_next = in2;
			default:                                         a_next = in1;
		endcase
	end

	// ************************************************************************
	// Stage register
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			dec_valid <= 1'b0;
			dec_unit  <= unit_move;
			dec_sub   <= '0;
			dec_a     <= '0;
			dec_b     <= '0;
			dec_error <= 1'b0;
		end else begin
			dec_valid <= op_valid;
			if (op_valid) begin                        // Payload only moves on a strobe
				dec_unit  <= unit_next;
				dec_sub   <= sub_next;
				dec_a     <= a_next;
				dec_b     <= in2;
				dec_error <= error_next;
			end
		end
	end

	// Opcode must be fully known whenever it is strobed in
	assert property (@(posedge clk) disable iff (reset) op_valid |-> !$isunknown(op));

endmodule

`default_nettype wire

/* logic/ula_execute.sv */
// Second ALU stage computing the decoded operation
// Result and error flag are registered one cycle after dec_valid

`default_nettype none

module ula_execute (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 dec_valid,
	input  ula_op_pkg::unit_t    dec_unit,
	input  ula_op_pkg::sub_t     dec_sub,
	input  ula_data_pkg::word_t  dec_a,
	input  ula_data_pkg::word_t  dec_b,
	input  logic                 dec_error,
	output logic                 exe_valid,
	output ula_data_pkg::word_t  exe_result,
	output logic                 exe_error
);

	import ula_data_pkg::*;
	import ula_op_pkg::*;

	word_t                  res_next;
	logic [shamt_width-1:0] shamt;
	logic                   big_shift;                 // Shift amount of 32 or more

	// Boolean answer widened to a data word of 1 or 0
	function automatic word_t flag_word(input logic flag);
		flag_word    = '0;
		flag_word[0] = flag;
	endfunction

	assign shamt     = dec_b[shamt_width-1:0];
	assign big_shift = |dec_b[word_width-1:shamt_width];  // Negative amounts count as big

	// ************************************************************************
	// Operation select
	// ************************************************************************

	always_comb begin
		res_next = '0;
		case (dec_unit)
			unit_move:    res_next = dec_a;            // Decode already picked in1 or in2
			unit_arith:
				case (dec_sub)
					sub_add: res_next = dec_a + dec_b;     // Wraps
					sub_mlt: res_next = dec_a * dec_b;     // Low 32 bits
					sub_sgn: res_next = (dec_a[word_width-1] == dec_b[word_width-1]) ?
						dec_b : -dec_b;                    // in2 with sign of in1
					default: res_next = '0;
				endcase
			unit_unary:
				case (dec_sub)
					sub_neg: res_next = -dec_a;
					sub_abs: res_next = dec_a[word_width-1] ? -dec_a : dec_a;
					sub_pst: res_next = dec_a[word_width-1] ? '0 : dec_a;
					default: res_next = ~dec_a;           // INV
				endcase
			unit_bitwise:
				case (dec_sub)
					sub_and: res_next = dec_a & dec_b;
					sub_orr: res_next = dec_a | dec_b;
					sub_xor: res_next = dec_a ^ dec_b;
					default: res_next = '0;
				endcase
			unit_cond:
				case (dec_sub)
					sub_lan: res_next = flag_word((dec_a != '0) && (dec_b != '0));
					sub_lor: res_next = flag_word((dec_a != '0) || (dec_b != '0));
					sub_lin: res_next = flag_word(dec_a == '0);  // Routed operand only
					default: res_next = '0;
				endcase
			unit_compare:
				case (dec_sub)
					sub_les: res_next = flag_word(dec_a < dec_b);   // Signed
					sub_gre: res_next = flag_word(dec_a > dec_b);
					sub_equ: res_next = flag_word(dec_a == dec_b);
					default: res_next = '0;
				endcase
			unit_shift:
				case (dec_sub)
					sub_shl: res_next = big_shift ? '0 : dec_a << shamt;
					sub_shr: res_next = big_shift ? '0 : dec_a >> shamt;
					sub_srs: res_next = big_shift ? $signed({word_width{dec_a[word_width-1]}}) :
						dec_a >>> shamt;                   // Sign fill
					default: res_next = '0;
				endcase
			default:      res_next = '0;
		endcase
		if (dec_error)
			res_next = '0;                             // Illegal opcode gives zero
	end

	// ************************************************************************
	// Stage register
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			exe_valid  <= 1'b0;
			exe_result <= '0;
			exe_error  <= 1'b0;
		end else begin
			exe_valid <= dec_valid;
			if (dec_valid) begin
				exe_result <= res_next;
				exe_error  <= dec_error;
			end
		end
	end

	// A legal entry always names one of the seven units
	assert property (@(posedge clk) disable iff (reset)
		dec_valid && !dec_error |-> dec_unit inside {unit_move, unit_arith, unit_unary,
			unit_bitwise, unit_cond, unit_compare, unit_shift});

endmodule

`default_nettype wire

/* logic/ula_result.sv */
// Third ALU stage holding the output register and the zero and negative flags
// Outputs hold their last value until the next valid result

`default_nettype none

module ula_result (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 exe_valid,
	input  ula_data_pkg::word_t  exe_result,
	input  logic                 exe_error,
	output logic                 result_valid,  // One cycle per operation
	output ula_data_pkg::word_t  result,
	output logic                 zero,
	output logic                 negative,
	output logic                 op_error
);

	import ula_data_pkg::*;

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
			result       <= '0;
			zero         <= 1'b1;                      // Matches the cleared result
			negative     <= 1'b0;
			op_error     <= 1'b0;
		end else begin
			result_valid <= exe_valid;
			if (exe_valid) begin
				result   <= exe_result;
				zero     <= (exe_result == '0);
				negative <= exe_result[word_width-1];  // Sign bit
				op_error <= exe_error;                 // Next legal op clears it
			end
		end
	end

	// An illegal operation reaches this stage with a zero result
	assert property (@(posedge clk) disable iff (reset)
		exe_valid && exe_error |-> exe_result == '0);

endmodule

`default_nettype wire

/* logic/ula.sv */
// Three-stage pipelined integer ALU for the accumulator machine
// Strobe op_valid with op, in1 and in2; result_valid follows three cycles later

`default_nettype none

module ula (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 op_valid,
	input  ula_op_pkg::op_t      op,
	input  ula_data_pkg::word_t  in1,           // Memory word
	input  ula_data_pkg::word_t  in2,           // Accumulator
	output logic                 result_valid,
	output ula_data_pkg::word_t  result,
	output logic                 zero,
	output logic                 negative,
	output logic                 op_error
);

	import ula_data_pkg::*;
	import ula_op_pkg::*;

	// Decode to execute
	logic  dec_valid;
	unit_t dec_unit;
	sub_t  dec_sub;
	word_t dec_a;
	word_t dec_b;
	logic  dec_error;

	// Execute to result
	logic  exe_valid;
	word_t exe_result;
	logic  exe_error;

	ula_decode decode_inst (
		.clk       (clk),
		.reset     (reset),
		.op_valid  (op_valid),
		.op        (op),
		.in1       (in1),
		.in2       (in2),
		.dec_valid (dec_valid),
		.dec_unit  (dec_unit),
		.dec_sub   (dec_sub),
		.dec_a     (dec_a),
		.dec_b     (dec_b),
		.dec_error (dec_error)
	);

	ula_execute execute_inst (
		.clk        (clk),
		.reset      (reset),
		.dec_valid  (dec_valid),
		.dec_unit   (dec_unit),
		.dec_sub    (dec_sub),
		.dec_a      (dec_a),
		.dec_b      (dec_b),
		.dec_error  (dec_error),
		.exe_valid  (exe_valid),
		.exe_result (exe_result),
		.exe_error  (exe_error)
	);

	ula_result result_inst (
		.clk          (clk),
		.reset        (reset),
		.exe_valid    (exe_valid),
		.exe_result   (exe_result),
		.exe_error    (exe_error),
		.result_valid (result_valid),
		.result       (result),
		.zero         (zero),
		.negative     (negative),
		.op_error     (op_error)
	);

endmodule

`default_nettype wire

/* include/ula_tb_checks.svh */
// Reference model, compare tasks and random source for the ALU testbench
// Included inside the testbench module body, after its error counters

`ifndef ULA_TB_CHECKS_SVH
`define ULA_TB_CHECKS_SVH

	// ************************************************************************
	// Reference model
	// ************************************************************************

	// Opcodes the ALU still implements
	function automatic logic is_legal(input op_t code);
		case (code)
			op_nop, op_lod, op_add, op_mlt, op_sgn,
			op_neg, op_neg_m, op_abs, op_abs_m, op_pst, op_pst_m,
			op_and, op_orr, op_xor, op_inv, op_inv_m,
			op_lan, op_lor, op_lin, op_lin_m,
			op_les, op_gre, op_equ, op_shl, op_shr, op_srs:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// m is the memory word (in1), acc the accumulator (in2)
	function automatic word_t model_result(input op_t code, input word_t m, input word_t acc);
		logic       big;
		logic [4:0] amt;
		word_t      r;
		big = ($unsigned(acc) >= 32);                  // Negative amounts are huge too
		amt = acc[4:0];
		case (code)
			op_nop:   r = acc;
			op_lod:   r = m;
			op_add:   r = m + acc;
			op_mlt:   r = m * acc;                     // Truncated to the word
			op_sgn:   r = ((m < 0) == (acc < 0)) ? acc : -acc;
			op_neg:   r = -acc;
			op_neg_m: r = -m;
			op_abs:   r = (acc < 0) ? -acc : acc;
			op_abs_m: r = (m < 0) ? -m : m;
			op_pst:   r = (acc < 0) ? 0 : acc;
			op_pst_m: r = (m < 0) ? 0 : m;
			op_and:   r = m & acc;
			op_orr:   r = m | acc;
			op_xor:   r = m ^ acc;
			op_inv:   r = ~acc;
			op_inv_m: r = ~m;
			op_lan:   r = ((m != 0) && (acc != 0)) ? 1 : 0;
			op_lor:   r = ((m != 0) || (acc != 0)) ? 1 : 0;
			op_lin:   r = (acc == 0) ? 1 : 0;
			op_lin_m: r = (m == 0) ? 1 : 0;
			op_les:   r = (m < acc) ? 1 : 0;
			op_gre:   r = (m > acc) ? 1 : 0;
			op_equ:   r = (m == acc) ? 1 : 0;
			op_shl:   r = big ? 0 : m << amt;
			op_shr:   r = big ? 0 : word_t'($unsigned(m) >> amt);
			op_srs:   r = big ? ((m < 0) ? -1 : 0) : m >>> amt;
			default:  r = 0;                           // Illegal opcode
		endcase
		return r;
	endfunction

	// ************************************************************************
	// Compare tasks
	// ************************************************************************

	task automatic compare_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	// Xorshift32 step
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic word_t random_word();
		rng_state = xorshift32(rng_state);             // Advances the shared state
		return word_t'(rng_state);
	endfunction

`endif

/* testbench/ula_tb.sv */
// Directed testbench for the three-stage pipelined ALU
// A negedge monitor checks every result, its flags and its latency in issue order

`default_nettype none

module ula_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import ula_data_pkg::*;
	import ula_op_pkg::*;

	localparam int    timeout_cycles = 10;
	localparam word_t min_word       = 32'sh8000_0000;
	localparam word_t max_word       = 32'sh7fff_ffff;

	logic  clk;
	logic  reset;
	logic  op_valid;
	op_t   op;
	word_t in1;
	word_t in2;
	logic  result_valid;
	word_t result;
	logic  zero;
	logic  negative;
	logic  op_error;

	int          value_errors = 0;
	int          other_errors = 0;
	int          cycle_count  = 0;                 // Rising edges so far
	int          results_seen = 0;
	logic [31:0] rng_state    = 32'hbbe4_b7d4;

	// Outstanding operations, oldest first
	word_t exp_result_q[$];
	logic  exp_error_q[$];
	int    exp_edge_q[$];                          // Cycle that carried the strobe

	`include "ula_tb_checks.svh"

	localparam op_t kept_ops [26] = '{op_nop, op_lod, op_add, op_mlt, op_sgn, op_neg,
		op_neg_m, op_abs, op_abs_m, op_pst, op_pst_m, op_and, op_orr, op_xor, op_inv,
		op_inv_m, op_lan, op_lor, op_lin, op_lin_m, op_les, op_gre, op_equ, op_shl,
		op_shr, op_srs};
	localparam word_t edge_values [4] = '{32'sd0, -32'sd1, min_word, max_word};

	ula ula_inst (
		.clk          (clk),
		.reset        (reset),
		.op_valid     (op_valid),
		.op           (op),
		.in1          (in1),
		.in2          (in2),
		.result_valid (result_valid),
		.result       (result),
		.zero         (zero),
		.negative     (negative),
		.op_error     (op_error)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;                     // 8 ns period
	end

	always @(posedge clk) cycle_count <= cycle_count + 1;

	// ************************************************************************
	// Result monitor
	// ************************************************************************

	always @(negedge clk) begin
		word_t exp_res;
		logic  exp_err;
		int    edge_at;
		if (result_valid === 1'b1) begin
			results_seen++;
			if (exp_result_q.size() == 0) begin
				$display("ERROR at %0t ns: result_valid rose with nothing in flight", $time);
				other_errors++;
			end else begin
				exp_res = exp_result_q.pop_front();
				exp_err = exp_error_q.pop_front();
				edge_at = exp_edge_q.pop_front();
				if (cycle_count - edge_at != 3) begin
					$display("ERROR at %0t ns: result came %0d cycles after its strobe, not 3",
						$time, cycle_count - edge_at);
					other_errors++;
				end
				compare_word("result", exp_res, result);
				check_flag("zero", exp_res == 0, zero);
				check_flag("negative", exp_res[word_width-1], negative);  // Sign bit
				check_flag("op_error", exp_err, op_error);
			end
		end
	end

	// ************************************************************************
	// Drivers
	// ************************************************************************

	task automatic strobe_op(input op_t code, input word_t a, input word_t b);
		@(posedge clk);
		#1;
		op_valid = 1'b1;
		op       = code;
		in1      = a;
		in2      = b;
		exp_result_q.push_back(model_result(code, a, b));
		exp_error_q.push_back(!is_legal(code));
		exp_edge_q.push_back(cycle_count);         // Strobe held during this cycle
	endtask

	task automatic release_inputs();
		@(posedge clk);
		#1;
		op_valid = 1'b0;
	endtask

	// Drains the pipeline or gives up after the timeout
	task automatic wait_results();
		int waited;
		waited = 0;
		while (exp_result_q.size() != 0 && waited < timeout_cycles) begin
			@(posedge clk);
			waited++;
		end
		if (exp_result_q.size() != 0) begin
			$display("ERROR at %0t ns: %0d results still missing after %0d cycles",
				$time, exp_result_q.size(), timeout_cycles);
			other_errors++;
			exp_result_q.delete();
			exp_error_q.delete();
			exp_edge_q.delete();
		end
	endtask

	task automatic run_single(input op_t code, input word_t a, input word_t b);
		strobe_op(code, a, b);
		release_inputs();
		wait_results();
	endtask

	// ************************************************************************
	// Directed tests
	// ************************************************************************

	task automatic reset_values();
		repeat (2) @(negedge clk);
		check_flag("result_valid", 1'b0, result_valid);
		check_flag("op_error", 1'b0, op_error);
		compare_word("result", 0, result);
	endtask

	// Edge pairs plus random pairs with small shift amounts among them
	task automatic all_opcodes();
		word_t a;
		word_t b;
		for (int i = 0; i < 26; i++) begin
			for (int j = 0; j < 4; j++)
				for (int k = 0; k < 4; k++)
					strobe_op(kept_ops[i], edge_values[j], edge_values[k]);
			repeat (4) begin
				a = random_word();
				b = random_word();
				strobe_op(kept_ops[i], a, b);
				strobe_op(kept_ops[i], a, b & 32'sh1f);
			end
			release_inputs();
			wait_results();
		end
	endtask

	// Accumulator form reads in2 and _M form reads in1
	task automatic unary_routing();
		op_t   acc_forms [5] = '{op_neg, op_abs, op_pst, op_inv, op_lin};
		op_t   mem_forms [5] = '{op_neg_m, op_abs_m, op_pst_m, op_inv_m, op_lin_m};
		word_t mem_vals  [4] = '{32'sh0000_1234, -32'sd5, 32'sd0, 32'sd3};
		word_t acc_vals  [4] = '{-32'sd77, 32'sd9, 32'sd3, 32'sd0};
		for (int i = 0; i < 5; i++) begin
			for (int j = 0; j < 4; j++) begin
				run_single(acc_forms[i], mem_vals[j], acc_vals[j]);
				run_single(mem_forms[i], mem_vals[j], acc_vals[j]);
			end
		end
	endtask

	task automatic shift_amounts();
		op_t   shift_ops [3] = '{op_shl, op_shr, op_srs};
		word_t values    [3] = '{32'sh8000_0001, 32'sh7f00_00f1, -32'sd2};
		word_t amounts   [7] = '{32'sd0, 32'sd1, 32'sd31, 32'sd32, 32'sd33, 32'sd1000, -32'sd1};
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++)
				for (int k = 0; k < 7; k++)
					strobe_op(shift_ops[i], values[j], amounts[k]);
			release_inputs();
			wait_results();
		end
	endtask

	// Twelve strobes on consecutive cycles with one illegal among them
	task automatic back_to_back();
		int pick;
		int seen_before;
		seen_before = results_seen;
		for (int i = 0; i < 12; i++) begin
			pick = int'($unsigned(random_word()) % 26);
			if (i == 5)
				strobe_op(6'd6, random_word(), random_word());  // DIV slot
			else
				strobe_op(kept_ops[pick], random_word(), random_word());
		end
		release_inputs();
		wait_results();
		if (results_seen - seen_before != 12) begin
			$display("ERROR at %0t ns: expected 12 results, saw %0d",
				$time, results_seen - seen_before);
			other_errors++;
		end
	endtask

	// Each illegal op is followed by a legal one that clears op_error
	task automatic illegal_opcodes();
		op_t bad_ops [5] = '{6'd3, 6'd6, 6'd5, 6'd46, 6'd63};
		for (int i = 0; i < 5; i++) begin
			run_single(bad_ops[i], random_word(), random_word());
			run_single(op_lod, 32'sd42, random_word());
		end
	endtask

	initial begin
		reset    = 1'b1;
		op_valid = 1'b0;
		op       = '0;
		in1      = '0;
		in2      = '0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		reset_values();
		all_opcodes();
		unary_routing();
		shift_amounts();
		back_to_back();
		illegal_opcodes();

		repeat (5) @(posedge clk);                 // Catch stray strobes
		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
logic/ula_data_pkg.sv
logic/ula_op_pkg.sv
logic/ula_decode.sv
logic/ula_execute.sv
logic/ula_result.sv
logic/ula.sv
testbench/ula_tb.sv

/* Makefile */
# Verilator flow for the pipelined ALU
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= ula_tb
RTL_TOP    ?= ula
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert
FAIL_MSG   ?= TEST RESULT: FAIL

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
